//--- vlog.f
+incdir+verilog
verilog/mdpx_pkg.sv
verilog/mdpx_frame_if.sv
verilog/nios_cmd_decoder.sv
verilog/frame_fifo.sv
verilog/mdpx_serializer.sv
verilog/medipix_bridge.sv
testbench/tb_clock_gen.sv
testbench/tb_medipix_bridge.sv

//--- testbench/tb_medipix_bridge.sv
// Testbench for the Nios to Medipix bridge.
// Table of host frames applied in a loop, chip side capture monitor,
// compare tasks for frames, operation codes and flags, and a cycle timeout.

`timescale 1ns/1ps
`include "mdpx_consts.svh"

module tb_medipix_bridge
  import mdpx_pkg::*;
;

  localparam int NROWS          = 11;
  localparam int TIMEOUT_CYCLES = NROWS * 110 + 200;

  typedef enum logic [1:0] {
    RES_SENT,
    RES_IGNORED,
    RES_DROPPED
  } result_e;

  typedef struct packed {
    logic [7:0]             cmd;
    logic [`FRAME_BITS-1:0] pay;
    logic                   rnd;       // payload drawn from $random.
    logic                   mid_sync;  // partial frame before the real one.
    logic                   group;     // next row follows without waiting.
    result_e                result;
  } row_t;

  logic       clock_nios;
  logic       arst_n;
  logic       en_nios;
  logic       sync_nios;
  logic [7:0] data_nios;
  logic [2:0] m;
  logic       clk_mdpx;
  logic       data_mdpx;
  logic       en_mdpx;
  logic       overflow;

  row_t                   tbl [NROWS];
  integer                 seed;
  int                     err_cnt;
  int unsigned            cycle_cnt;
  logic                   ovf_exp;
  logic [`FRAME_BITS-1:0] exp_pay [$];
  logic [2:0]             exp_m [$];
  logic [`FRAME_BITS-1:0] cap;
  int                     bit_idx;

  tb_clock_gen #(.PERIOD_NS(40)) u_clock_gen (.clock_nios(clock_nios));

  medipix_bridge DUT (
    .clock_nios (clock_nios),
    .arst_n     (arst_n),
    .en_nios    (en_nios),
    .sync_nios  (sync_nios),
    .data_nios  (data_nios),
    .m          (m),
    .clk_mdpx   (clk_mdpx),
    .data_mdpx  (data_mdpx),
    .en_mdpx    (en_mdpx),
    .overflow   (overflow)
  );

  task abort_run();
    err_cnt = err_cnt + 1;
    $display("Errors found");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_frame(input string name, input payload_u got, input payload_u exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_m(input string name, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic set_row(input int idx, input logic [7:0] cmd,
                         input logic [`FRAME_BITS-1:0] pay, input logic rnd,
                         input logic mid_sync, input logic group, input result_e res);
    logic [31:0] hi;
    logic [31:0] lo;
    tbl[idx].cmd      = cmd;
    tbl[idx].pay      = pay;
    tbl[idx].rnd      = rnd;
    tbl[idx].mid_sync = mid_sync;
    tbl[idx].group    = group;
    tbl[idx].result   = res;
    if (rnd) begin
      hi = $random(seed);
      lo = $random(seed);
      tbl[idx].pay = {hi[15:0], lo};
    end
  endtask

  task automatic load_table();
    set_row(0, `CMD_LOAD_OMR, 48'hA5C3_1F0E_7729, 1'b0, 1'b0, 1'b0, RES_SENT);
    set_row(1, `CMD_LOAD_DAC, 48'h3C0F_F00F_5AA5, 1'b0, 1'b0, 1'b0, RES_SENT);
    set_row(2, 8'h7E,         48'hFFFF_0000_FFFF, 1'b0, 1'b0, 1'b0, RES_IGNORED);
    set_row(3, `CMD_LOAD_OMR, '0, 1'b1, 1'b0, 1'b0, RES_SENT);
    set_row(4, `CMD_LOAD_DAC, '0, 1'b1, 1'b1, 1'b0, RES_SENT);
    // six frames back to back, the last finds the buffer full.
    set_row(5,  `CMD_LOAD_OMR, '0, 1'b1, 1'b0, 1'b1, RES_SENT);
    set_row(6,  `CMD_LOAD_DAC, '0, 1'b1, 1'b0, 1'b1, RES_SENT);
    set_row(7,  `CMD_LOAD_OMR, '0, 1'b1, 1'b0, 1'b1, RES_SENT);
    set_row(8,  `CMD_LOAD_DAC, '0, 1'b1, 1'b0, 1'b1, RES_SENT);
    set_row(9,  `CMD_LOAD_OMR, '0, 1'b1, 1'b0, 1'b1, RES_SENT);
    set_row(10, `CMD_LOAD_DAC, '0, 1'b1, 1'b0, 1'b0, RES_DROPPED);
  endtask

  task automatic send_byte(input logic [7:0] b, input logic sync);
    @(negedge clock_nios);
    en_nios   = 1'b1;
    sync_nios = sync;
    data_nios = b;
  endtask

  task automatic bus_idle();
    @(negedge clock_nios);
    en_nios   = 1'b0;
    sync_nios = 1'b0;
    data_nios = 8'h00;
  endtask

  task automatic send_frame(input row_t r);
    logic [7:0] junk;
    int         i;
    if (r.mid_sync) begin
      send_byte(r.cmd, 1'b1);
      for (i = 0; i < 3; i++) begin
        junk = $random(seed);
        send_byte(junk, 1'b0);  // partial payload, thrown away by the resync.
      end
    end
    send_byte(r.cmd, 1'b1);
    for (i = 0; i < `FRAME_BYTES; i++) begin
      send_byte(r.pay[`FRAME_BITS-1-8*i -: 8], 1'b0);
    end
    bus_idle();
  endtask

  task automatic wait_drained();
    while (exp_pay.size() != 0) begin
      @(posedge clock_nios);
    end
  endtask

  // chip samples on the clk_mdpx rise, so take one bit per high phase.
  always @(negedge clock_nios) begin
    if (arst_n) begin
      if (en_mdpx && clk_mdpx) begin
        if (bit_idx == 0 && exp_pay.size() == 0) begin
          $display("Unexpected en_mdpx burst at %0t ns with no frame pending", $time);
          abort_run();
        end
        check_m("m", m, exp_m[0]);
        cap     = {cap[`FRAME_BITS-2:0], data_mdpx};
        bit_idx = bit_idx + 1;
        if (bit_idx == `FRAME_BITS) begin
          check_frame("data_mdpx", cap, exp_pay[0]);
          exp_pay.delete(0);
          exp_m.delete(0);
          bit_idx = 0;
        end
      end else if (!en_mdpx && bit_idx != 0) begin
        $display("en_mdpx fell after %0d of 48 bits at %0t ns", bit_idx, $time);
        abort_run();
      end
    end
  end

  always @(posedge clock_nios) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles waiting for chip frames", cycle_cnt);
      abort_run();
    end
  end

  initial begin
    row_t r;
    int   i;
    en_nios   = 1'b0;
    sync_nios = 1'b0;
    data_nios = 8'h00;
    arst_n    = 1'b0;
    seed      = 32'h1b3a;
    err_cnt   = 0;
    cycle_cnt = 0;
    ovf_exp   = 1'b0;
    bit_idx   = 0;
    cap       = '0;
    load_table();

    repeat (8) @(posedge clock_nios);
    @(negedge clock_nios);
    arst_n = 1'b1;
    @(negedge clock_nios);
    check_flag("en_mdpx", en_mdpx, 1'b0);
    check_flag("clk_mdpx", clk_mdpx, 1'b0);
    check_flag("data_mdpx", data_mdpx, 1'b0);
    check_m("m", m, 3'b000);
    check_flag("overflow", overflow, 1'b0);

    for (i = 0; i < NROWS; i++) begin
      r = tbl[i];
      if (r.result == RES_SENT) begin
        exp_pay.push_back(r.pay);
        // OMR m is the top three payload bits.
        exp_m.push_back((r.cmd == `CMD_LOAD_DAC) ? `M_LOAD_DAC : r.pay[`FRAME_BITS-1 -: 3]);
      end
      if (r.result == RES_DROPPED) begin
        ovf_exp = 1'b1;
      end
      send_frame(r);
      if (!r.group) begin
        wait_drained();
        check_flag("overflow", overflow, ovf_exp);
      end
    end

    repeat (120) @(posedge clock_nios);  // room for any stray burst.
    check_flag("overflow", overflow, ovf_exp);

    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- testbench/tb_clock_gen.sv
// Free-running clock source for the bridge testbench.

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clock_nios
);

  initial begin
    clock_nios = 1'b0;
  end

  always begin
    #(PERIOD_NS / 2) clock_nios = ~clock_nios;  // 50% duty.
  end

endmodule

//--- verilog/medipix_bridge.sv
// Bridge from the Nios host byte stream to the Medipix serial port.
// Command decoder, frame buffer and chip serializer, linked by two
// valid/ready frame links.

`timescale 1ns/1ps
`include "mdpx_consts.svh"

module medipix_bridge
  import mdpx_pkg::*;
(
  input  logic       clock_nios,
  input  logic       arst_n,
  input  logic       en_nios,
  input  logic       sync_nios,
  input  logic [7:0] data_nios,
  output logic [2:0] m,
  output logic       clk_mdpx,
  output logic       data_mdpx,
  output logic       en_mdpx,
  output logic       overflow
);

  mdpx_frame_if dec_to_fifo ();
  mdpx_frame_if fifo_to_ser ();

  nios_cmd_decoder u_nios_cmd_decoder (
    .clock_nios (clock_nios),
    .arst_n     (arst_n),
    .en_nios    (en_nios),
    .sync_nios  (sync_nios),
    .data_nios  (data_nios),
    .overflow   (overflow),
    .out        (dec_to_fifo.source)
  );

  frame_fifo #(
    .DEPTH (`FIFO_DEPTH)
  ) u_frame_fifo (
    .clock_nios (clock_nios),
    .arst_n     (arst_n),
    .in         (dec_to_fifo.sink),
    .out        (fifo_to_ser.source)
  );

  mdpx_serializer u_mdpx_serializer (
    .clock_nios (clock_nios),
    .arst_n     (arst_n),
    .in         (fifo_to_ser.sink),
    .m          (m),
    .clk_mdpx   (clk_mdpx),
    .data_mdpx  (data_mdpx),
    .en_mdpx    (en_mdpx)
  );

endmodule

//--- verilog/mdpx_serializer.sv
// Chip side serializer for OMR and DAC frames.
// Drives the operation code, then shifts 48 bits msb first, two cycles
// per bit with clk_mdpx high in the second, then rests two cycles.

`timescale 1ns/1ps
`include "mdpx_consts.svh"

module mdpx_serializer
  import mdpx_pkg::*;
(
  input  logic       clock_nios,
  input  logic       arst_n,
  mdpx_frame_if.sink in,
  output logic [2:0] m,
  output logic       clk_mdpx,
  output logic       data_mdpx,
  output logic       en_mdpx
);

  localparam int         BIT_W = $clog2(`FRAME_BITS);
  localparam logic [1:0] GAP   = 2'd2;

  logic                   busy;
  logic                   phase;    // high in the second half of a bit.
  logic [BIT_W-1:0]       bit_cnt;
  logic [1:0]             gap_cnt;
  logic [`FRAME_BITS-1:0] shift_q;
  logic                   take;
  logic                   bit_done;
  payload_u               pay;

  assign pay      = in.frame.payload;
  assign in.ready = !busy && (gap_cnt == 2'd0);
  assign take     = in.valid && in.ready;
  assign bit_done = busy && phase;

  always_ff @(posedge clock_nios or negedge arst_n) begin
    if (!arst_n) begin
      busy    <= 1'b0;
      phase   <= 1'b0;
      bit_cnt <= '0;
      gap_cnt <= 2'd0;
      m       <= 3'b000;
    end else if (take) begin
      busy    <= 1'b1;
      phase   <= 1'b0;
      bit_cnt <= '0;
      m       <= (in.frame.cmd == CMD_OMR) ? pay.fields.m : `M_LOAD_DAC;
    end else if (busy) begin
      phase <= !phase;
      if (bit_done) begin
        if (bit_cnt == BIT_W'(`FRAME_BITS - 1)) begin
          busy    <= 1'b0;
          gap_cnt <= GAP;  // chip rest time before the next frame.
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end else if (gap_cnt != 2'd0) begin
      gap_cnt <= gap_cnt - 1'b1;
    end
  end

  always_ff @(posedge clock_nios) begin
    if (take) begin
      shift_q <= pay.raw;
    end else if (bit_done) begin
      shift_q <= {shift_q[`FRAME_BITS-2:0], 1'b0};
    end
  end

  assign en_mdpx   = busy;
  assign clk_mdpx  = phase;
  assign data_mdpx = busy & shift_q[`FRAME_BITS-1];

  a_clk_inside_en: assert property (
    @(posedge clock_nios) disable iff (!arst_n)
      clk_mdpx |-> en_mdpx
  );

endmodule

//--- verilog/frame_fifo.sv
// Register-array buffer for command frames.
// Read and write pointers with an occupancy count, push and pop
// allowed in the same cycle.

`timescale 1ns/1ps
`include "mdpx_consts.svh"

module frame_fifo
  import mdpx_pkg::*;
#(
  parameter int DEPTH = `FIFO_DEPTH
) (
  input  logic         clock_nios,
  input  logic         arst_n,
  mdpx_frame_if.sink   in,
  mdpx_frame_if.source out
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  frame_t        mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          empty;
  logic          push;
  logic          pop;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    next_ptr = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);

  assign in.ready  = !full;
  assign out.valid = !empty;
  assign out.frame = mem[rd_ptr];  // head entry appears the cycle after its push.

  assign push = in.valid && in.ready;
  assign pop  = out.valid && out.ready;

  always_ff @(posedge clock_nios) begin
    if (push) begin
      mem[wr_ptr] <= in.frame;
    end
  end

  always_ff @(posedge clock_nios or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither.
      endcase
    end
  end

  // a full buffer takes no frame, so its write pointer stays put.
  a_no_push_full: assert property (
    @(posedge clock_nios) disable iff (!arst_n)
      full |=> $stable(wr_ptr)
  );

  a_no_pop_empty: assert property (
    @(posedge clock_nios) disable iff (!arst_n)
      empty |=> $stable(rd_ptr)
  );

endmodule

//--- verilog/nios_cmd_decoder.sv
// Host byte receiver building command frames.
// Counts payload bytes after a sync mark, offers the frame for one cycle
// and raises a sticky overflow when the buffer cannot take it.

`timescale 1ns/1ps
`include "mdpx_consts.svh"

module nios_cmd_decoder
  import mdpx_pkg::*;
(
  input  logic         clock_nios,
  input  logic         arst_n,
  input  logic         en_nios,
  input  logic         sync_nios,
  input  logic [7:0]   data_nios,
  output logic         overflow,
  mdpx_frame_if.source out
);

  localparam int CNT_W = $clog2(`FRAME_BYTES + 1);

  logic [CNT_W-1:0]       byte_cnt;
  logic                   active;     // inside a frame with a known command.
  cmd_e                   cmd_q;
  logic [`FRAME_BITS-1:0] asm_q;
  logic                   valid_q;
  logic                   known_cmd;
  logic                   take_pay;
  logic                   last_byte;

  assign known_cmd = (data_nios == `CMD_LOAD_OMR) || (data_nios == `CMD_LOAD_DAC);
  assign take_pay  = en_nios && !sync_nios && active;
  assign last_byte = (byte_cnt == CNT_W'(`FRAME_BYTES - 1));

  always_ff @(posedge clock_nios or negedge arst_n) begin
    if (!arst_n) begin
      byte_cnt <= '0;
      active   <= 1'b0;
      cmd_q    <= CMD_OMR;
    end else if (en_nios && sync_nios) begin
      byte_cnt <= '0;         // any sync restarts assembly.
      active   <= known_cmd;  // unknown bytes idle until next sync.
      cmd_q    <= (data_nios == `CMD_LOAD_DAC) ? CMD_DAC : CMD_OMR;
    end else if (take_pay) begin
      if (last_byte) begin
        byte_cnt <= '0;
        active   <= 1'b0;
      end else begin
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  // msb first, so each new byte shifts in from the bottom.
  always_ff @(posedge clock_nios) begin
    if (take_pay) begin
      asm_q <= {asm_q[`FRAME_BITS-9:0], data_nios};
    end
  end

  always_ff @(posedge clock_nios or negedge arst_n) begin
    if (!arst_n) begin
      valid_q  <= 1'b0;
      overflow <= 1'b0;
    end else begin
      valid_q <= take_pay && last_byte;
      if (valid_q && !out.ready) begin
        overflow <= 1'b1;  // the frame is lost since the host cannot wait.
      end
    end
  end

  assign out.valid = valid_q;
  assign out.frame = {cmd_q, asm_q};

  a_byte_cnt_range: assert property (
    @(posedge clock_nios) disable iff (!arst_n)
      byte_cnt <= CNT_W'(`FRAME_BYTES)
  );

endmodule

//--- verilog/mdpx_frame_if.sv
// Valid/ready link carrying one command frame per transfer.
// Source and sink modports for the two ends.

`timescale 1ns/1ps

interface mdpx_frame_if;

  logic             valid;
  logic             ready;
  mdpx_pkg::frame_t frame;  // held stable while valid waits for ready.

  // driver side.
  modport source (
    output valid,
    output frame,
    input  ready
  );

  // receiver side.
  modport sink (
    input  valid,
    input  frame,
    output ready
  );

endinterface

//--- verilog/mdpx_pkg.sv
// Frame types for the host to chip command path.
// Command enum, OMR field layout, payload union and the frame itself.

`include "mdpx_consts.svh"

package mdpx_pkg;

  typedef enum logic {
    CMD_OMR = 1'b0,
    CMD_DAC = 1'b1
  } cmd_e;

  // OMR layout, m sits in the first bits shifted out.
  typedef struct packed {
    logic [2:0] m;
    logic       crw_srw;
    logic       polarity;
    logic [1:0] ps;
    logic       disc_csm_spm;
    logic       enable_tp;
    logic [1:0] count_l;
    logic [2:0] column_block;
    logic       column_blocksel;
    logic [2:0] row_block;
    logic       row_blocksel;
    logic       equalization;
    logic       colour_mode;
    logic       csm_spm;
    logic       info_header;
    logic [4:0] fuse_sel;
    logic [6:0] fuse_pulse_wd;
    logic [1:0] gain_mode;
    logic [4:0] sense_dac;
    logic [4:0] ext_dac;
    logic       ext_bg_sel;
  } omr_fields_t;

  typedef union packed {
    omr_fields_t            fields;  // decoded OMR view.
    logic [`FRAME_BITS-1:0] raw;     // bit stream view.
  } payload_u;

  typedef struct packed {
    cmd_e     cmd;
    payload_u payload;
  } frame_t;

endpackage

//--- verilog/mdpx_consts.svh
// Constants shared by the bridge RTL and its testbench.
// Host command bytes, chip operation codes, frame sizes and buffer depth.

`ifndef MDPX_CONSTS_SVH
`define MDPX_CONSTS_SVH

// host command bytes, sent with sync_nios.
`define CMD_LOAD_OMR 8'h01
`define CMD_LOAD_DAC 8'h02

// operation code on m while a DAC word is shifted.
`define M_LOAD_DAC 3'b011

// payload size of one command frame.
`define FRAME_BITS 48
`define FRAME_BYTES 6

// default depth of the frame buffer.
`define FIFO_DEPTH 4

`endif
